// File: hw/scu_pkg.sv
// System control unit package with data register layout, CSR codes and data views
package scu_pkg;

    // --------------------
    // Data register layout
    // --------------------
    localparam int unsigned DR_OP_W   = 2;
    localparam int unsigned DR_ADDR_W = 2;
    localparam int unsigned DR_DATA_W = 4;
    localparam int unsigned DR_W      = DR_OP_W + DR_ADDR_W + DR_DATA_W;

    // Field offsets, data sits at the LSB end
    localparam int unsigned DR_DATA_LSB = 0;
    localparam int unsigned DR_ADDR_LSB = DR_DATA_LSB + DR_DATA_W;
    localparam int unsigned DR_OP_LSB   = DR_ADDR_LSB + DR_ADDR_W;

    // Reset channels and status sync depth
    localparam int unsigned NUM_RST_CHAN       = 3;
    localparam int unsigned STATUS_SYNC_STAGES = 2;

    // Operation codes
    localparam logic [DR_OP_W-1:0] OP_READ    = 'd0;
    localparam logic [DR_OP_W-1:0] OP_WRITE   = 'd1;
    localparam logic [DR_OP_W-1:0] OP_SETBITS = 'd2;
    localparam logic [DR_OP_W-1:0] OP_CLRBITS = 'd3;

    // CSR addresses
    localparam logic [DR_ADDR_W-1:0] ADDR_CONTROL = 'd0;
    localparam logic [DR_ADDR_W-1:0] ADDR_MODE    = 'd1;
    localparam logic [DR_ADDR_W-1:0] ADDR_STATUS  = 'd2;
    localparam logic [DR_ADDR_W-1:0] ADDR_STICKY  = 'd3;

    // Channel order in rst_n_o and rdc_qlfy_o
    localparam int unsigned CHAN_SYS  = 0;
    localparam int unsigned CHAN_CORE = 1;
    localparam int unsigned CHAN_HDU  = 2;

    // --------------------
    // CSR data word, one word seen as CONTROL, MODE or STATUS
    // Reserved bits read 0
    typedef union packed {
        struct packed {
            logic [1:0] rsvd;
            logic       core_reset;
            logic       sys_reset;
        } control;
        struct packed {
            logic [2:0] rsvd;
            logic       hdu_rst_bhv;
        } mode;
        struct packed {
            logic rsvd;
            logic hdu;
            logic core;
            logic sys;
        } status;
    } csr_data_u;

endpackage : scu_pkg

// File: hw/scu_dr_chain.sv
// Scan chain data register, shift and shadow stages with CSR read mux and write builder
`timescale 1ns/1ps

module scu_dr_chain (
    input  logic               clk,
    input  logic               pwrup_rst_n_sync,
    // Scan strobes
    input  logic               ch_sel_i,
    input  logic               ch_id_i,
    input  logic               ch_capture_i,
    input  logic               ch_shift_i,
    input  logic               ch_update_i,
    input  logic               ch_tdi_i,
    // Current CSR values
    input  scu_pkg::csr_data_u control_i,
    input  scu_pkg::csr_data_u mode_i,
    input  scu_pkg::csr_data_u status_i,
    input  scu_pkg::csr_data_u sticky_i,
    output logic               ch_tdo_o,
    // CSR write side
    output scu_pkg::csr_data_u wdata_o,
    output logic               ctrl_wr_o,
    output logic               mode_wr_o,
    output logic               sticky_wr_o
);

    import scu_pkg::*;

    // Strobe decode
    logic                   chain_sel;
    logic                   cap_req;
    logic                   shft_req;
    logic                   upd_req;

    // Shift and shadow stages
    logic [DR_W-1:0]        shift_ff;
    logic [DR_W-1:0]        shadow_ff;

    // Shifted fields
    logic [DR_OP_W-1:0]     op;
    logic [DR_ADDR_W-1:0]   addr;
    csr_data_u              shift_data;

    csr_data_u              rdata;
    csr_data_u              wdata;

    // --------------------
    // Chain select, only chain id 0 belongs to this unit
    assign chain_sel = ch_sel_i & (ch_id_i == 1'b0);
    assign cap_req   = chain_sel & ch_capture_i;
    assign shft_req  = chain_sel & ch_shift_i;
    assign upd_req   = chain_sel & ch_update_i;

    // Field split of the shift stage
    assign op         = shift_ff[DR_OP_LSB +: DR_OP_W];
    assign addr       = shift_ff[DR_ADDR_LSB +: DR_ADDR_W];
    assign shift_data = shift_ff[DR_DATA_LSB +: DR_DATA_W];

    // Capture loads shadow, shift moves right with TDI at the MSB
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            shift_ff <= '0;
        end else if (cap_req) begin
            shift_ff <= shadow_ff;
        end else if (shft_req) begin
            shift_ff <= {ch_tdi_i, shift_ff[DR_W-1:1]};
        end
    end

    // Shadow keeps op/addr and the resulting register value
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            shadow_ff <= '0;
        end else if (upd_req) begin
            shadow_ff <= {op, addr, wdata};
        end
    end

    assign ch_tdo_o = shift_ff[0];

    // --------------------
    // Read mux by address
    always_comb begin
        case (addr)
            ADDR_CONTROL: rdata = control_i;
            ADDR_MODE:    rdata = mode_i;
            ADDR_STATUS:  rdata = status_i;
            ADDR_STICKY:  rdata = sticky_i;
            default:      rdata = '0;
        endcase
    end

    // Write data by op, READ writes back the current value
    always_comb begin
        case (op)
            OP_WRITE:   wdata = shift_data;
            OP_READ:    wdata = rdata;
            OP_SETBITS: wdata = rdata | shift_data;
            OP_CLRBITS: wdata = rdata & ~shift_data;
            default:    wdata = shift_data;
        endcase
    end

    assign wdata_o = wdata;

    // One strobe per non-READ update
    // STATUS has no strobe, STICKY only takes CLRBITS
    assign ctrl_wr_o   = upd_req & (op != OP_READ) & (addr == ADDR_CONTROL);
    assign mode_wr_o   = upd_req & (op != OP_READ) & (addr == ADDR_MODE);
    assign sticky_wr_o = upd_req & (op == OP_CLRBITS) & (addr == ADDR_STICKY);

endmodule : scu_dr_chain

// File: hw/scu_csr_regs.sv
// CONTROL and MODE registers with reset request combining for the three channels
`timescale 1ns/1ps

module scu_csr_regs (
    input  logic                             clk,
    input  logic                             pwrup_rst_n_sync,
    input  scu_pkg::csr_data_u               wdata_i,
    input  logic                             ctrl_wr_i,
    input  logic                             mode_wr_i,
    // External level resets
    input  logic                             rst_n_i,
    input  logic                             cpu_rst_n_i,
    input  logic                             ndm_rst_n_i,
    input  logic                             hart_rst_n_i,
    output scu_pkg::csr_data_u               control_o,
    output scu_pkg::csr_data_u               mode_o,
    output logic [scu_pkg::NUM_RST_CHAN-1:0] rst_req_n_o
);

    import scu_pkg::*;

    // Only the defined bits have storage
    logic sys_reset_ff;
    logic core_reset_ff;
    logic hdu_rst_bhv_ff;

    // Intermediate requests, active low
    logic sys_req_n;
    logic core_req_n;
    logic hdu_req_n;

    // --------------------
    // CONTROL, software system and core resets
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            sys_reset_ff  <= 1'b0;
            core_reset_ff <= 1'b0;
        end else if (ctrl_wr_i) begin
            sys_reset_ff  <= wdata_i.control.sys_reset;
            core_reset_ff <= wdata_i.control.core_reset;
        end
    end

    // MODE, set keeps HDU out of core reset
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            hdu_rst_bhv_ff <= 1'b0;
        end else if (mode_wr_i) begin
            hdu_rst_bhv_ff <= wdata_i.mode.hdu_rst_bhv;
        end
    end

    // Readback views, reserved bits zero
    always_comb begin
        control_o                    = '0;
        control_o.control.sys_reset  = sys_reset_ff;
        control_o.control.core_reset = core_reset_ff;
        mode_o                       = '0;
        mode_o.mode.hdu_rst_bhv      = hdu_rst_bhv_ff;
    end

    // --------------------
    // Request chain: sys feeds core, core feeds HDU
    assign sys_req_n  = ~sys_reset_ff & ndm_rst_n_i & rst_n_i;
    assign core_req_n = sys_req_n & hart_rst_n_i & ~core_reset_ff & cpu_rst_n_i;
    assign hdu_req_n  = core_req_n | hdu_rst_bhv_ff;

    assign rst_req_n_o[CHAN_SYS]  = sys_req_n;
    assign rst_req_n_o[CHAN_CORE] = core_req_n;
    assign rst_req_n_o[CHAN_HDU]  = hdu_req_n;

endmodule : scu_csr_regs

// File: hw/scu_rst_chan.sv
// Reset channel that drops its RDC qualifier one cycle ahead of the reset
`timescale 1ns/1ps

module scu_rst_chan (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_req_n_i,
    output logic rst_n_o,
    output logic rdc_qlfy_o
);

    // Two stage pipe of the request
    logic req_ff;
    logic rst_ff;

    // --------------------
    // Both stages come up asserted after power-up
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            req_ff <= 1'b0;
            rst_ff <= 1'b0;
        end else begin
            req_ff <= rst_req_n_i;
            rst_ff <= req_ff;
        end
    end

    // Reset follows the second stage
    assign rst_n_o = rst_ff;

    // Qualifier falls with the first stage, one cycle early
    // and rises only once the reset itself is released
    assign rdc_qlfy_o = req_ff & rst_ff;

endmodule : scu_rst_chan

// File: hw/scu_rst_status.sv
// Reset status synchronizers with rising edge detect and STICKY_STATUS register
`timescale 1ns/1ps

module scu_rst_status (
    input  logic                             clk,
    input  logic                             pwrup_rst_n_sync,
    input  logic [scu_pkg::NUM_RST_CHAN-1:0] rst_n_i,
    input  scu_pkg::csr_data_u               wdata_i,
    input  logic                             sticky_wr_i,
    output scu_pkg::csr_data_u               status_o,
    output scu_pkg::csr_data_u               sticky_o,
    output logic                             sys_rst_status_o,
    output logic                             core_rst_status_o
);

    import scu_pkg::*;

    // Status sync stages, stage 0 samples the inverted resets
    logic [NUM_RST_CHAN-1:0] sync_ff [STATUS_SYNC_STAGES];
    logic [NUM_RST_CHAN-1:0] status_vec;
    logic [NUM_RST_CHAN-1:0] status_dly_ff;
    logic [NUM_RST_CHAN-1:0] status_rise;

    // Sticky bits and their clear value
    logic [NUM_RST_CHAN-1:0] sticky_ff;
    logic [NUM_RST_CHAN-1:0] wr_bits;

    // --------------------
    // Resets are asserted at power-up, so status starts high
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            for (int s = 0; s < STATUS_SYNC_STAGES; s++) begin
                sync_ff[s] <= '1;
            end
            status_dly_ff <= '1;
        end else begin
            sync_ff[0] <= ~rst_n_i;
            for (int s = 1; s < STATUS_SYNC_STAGES; s++) begin
                sync_ff[s] <= sync_ff[s-1];
            end
            status_dly_ff <= status_vec;
        end
    end

    assign status_vec  = sync_ff[STATUS_SYNC_STAGES-1];
    assign status_rise = status_vec & ~status_dly_ff;

    // --------------------
    // CLRBITS result from the chain, mapped per channel
    assign wr_bits[CHAN_SYS]  = wdata_i.status.sys;
    assign wr_bits[CHAN_CORE] = wdata_i.status.core;
    assign wr_bits[CHAN_HDU]  = wdata_i.status.hdu;

    // Rising edge sets, wins over a clear in the same cycle
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (~pwrup_rst_n_sync) begin
            sticky_ff <= '0;
        end else begin
            for (int i = 0; i < NUM_RST_CHAN; i++) begin
                if (status_rise[i]) begin
                    sticky_ff[i] <= 1'b1;
                end else if (sticky_wr_i) begin
                    sticky_ff[i] <= wr_bits[i];
                end
            end
        end
    end

    // Register views, reserved bit zero
    always_comb begin
        status_o             = '0;
        status_o.status.sys  = status_vec[CHAN_SYS];
        status_o.status.core = status_vec[CHAN_CORE];
        status_o.status.hdu  = status_vec[CHAN_HDU];
        sticky_o             = '0;
        sticky_o.status.sys  = sticky_ff[CHAN_SYS];
        sticky_o.status.core = sticky_ff[CHAN_CORE];
        sticky_o.status.hdu  = sticky_ff[CHAN_HDU];
    end

    assign sys_rst_status_o  = status_vec[CHAN_SYS];
    assign core_rst_status_o = status_vec[CHAN_CORE];

endmodule : scu_rst_status

// File: hw/scu_top.sv
// System control unit top level, scan chain CSRs driving three qualified reset channels
`timescale 1ns/1ps

module scu_top (
    input  logic                            clk,
    input  logic                            pwrup_rst_n_sync,
    // Level resets, already synchronous to clk
    input  logic                            rst_n_i,
    input  logic                            cpu_rst_n_i,
    input  logic                            ndm_rst_n_i,
    input  logic                            hart_rst_n_i,
    // Scan chain strobes
    input  logic                            ch_sel_i,
    input  logic                            ch_id_i,
    input  logic                            ch_capture_i,
    input  logic                            ch_shift_i,
    input  logic                            ch_update_i,
    input  logic                            ch_tdi_i,
    output logic                            ch_tdo_o,
    // Generated resets and their RDC qualifiers
    output logic [scu_pkg::NUM_RST_CHAN-1:0] rst_n_o,
    output logic [scu_pkg::NUM_RST_CHAN-1:0] rdc_qlfy_o,
    output logic                            sys_rst_status_o,
    output logic                            core_rst_status_o
);

    import scu_pkg::*;

    // CSR data paths
    csr_data_u                  control;
    csr_data_u                  mode;
    csr_data_u                  status;
    csr_data_u                  sticky;
    csr_data_u                  wdata;

    // Write strobes from the chain
    logic                       ctrl_wr;
    logic                       mode_wr;
    logic                       sticky_wr;

    // Per channel reset requests
    logic [NUM_RST_CHAN-1:0]    rst_req_n;

    // --------------------
    // Scan chain and CSR access
    scu_dr_chain u_dr_chain (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .ch_sel_i         (ch_sel_i),
        .ch_id_i          (ch_id_i),
        .ch_capture_i     (ch_capture_i),
        .ch_shift_i       (ch_shift_i),
        .ch_update_i      (ch_update_i),
        .ch_tdi_i         (ch_tdi_i),
        .control_i        (control),
        .mode_i           (mode),
        .status_i         (status),
        .sticky_i         (sticky),
        .ch_tdo_o         (ch_tdo_o),
        .wdata_o          (wdata),
        .ctrl_wr_o        (ctrl_wr),
        .mode_wr_o        (mode_wr),
        .sticky_wr_o      (sticky_wr)
    );

    // CONTROL, MODE and request combining
    scu_csr_regs u_csr_regs (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .wdata_i          (wdata),
        .ctrl_wr_i        (ctrl_wr),
        .mode_wr_i        (mode_wr),
        .rst_n_i          (rst_n_i),
        .cpu_rst_n_i      (cpu_rst_n_i),
        .ndm_rst_n_i      (ndm_rst_n_i),
        .hart_rst_n_i     (hart_rst_n_i),
        .control_o        (control),
        .mode_o           (mode),
        .rst_req_n_o      (rst_req_n)
    );

    // --------------------
    // One qualifier/reset sequencer per channel
    for (genvar i = 0; i < NUM_RST_CHAN; i++) begin : g_rst_chan
        scu_rst_chan u_rst_chan (
            .clk              (clk),
            .pwrup_rst_n_sync (pwrup_rst_n_sync),
            .rst_req_n_i      (rst_req_n[i]),
            .rst_n_o          (rst_n_o[i]),
            .rdc_qlfy_o       (rdc_qlfy_o[i])
        );
    end

    // Status sync back and STICKY_STATUS
    scu_rst_status u_rst_status (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_o),
        .wdata_i           (wdata),
        .sticky_wr_i       (sticky_wr),
        .status_o          (status),
        .sticky_o          (sticky),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o)
    );

endmodule : scu_top

// File: testbench/tb_clk_gen.sv
// Free running testbench clock source, 100 ns period
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    // Half of the 100 ns period
    localparam int unsigned HALF_PERIOD_NS = 50;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule : tb_clk_gen

// File: testbench/tb_scu.sv
// Trace driven testbench for the system control unit scan chain and reset channels
`timescale 1ns/1ps

module tb_scu;

    import scu_pkg::*;

    localparam string       TRACE_FILE      = "testbench/scu_trace.txt";
    localparam int unsigned RST_CYCLES      = 5;
    localparam int unsigned CYCLES_PER_STEP = 14;
    localparam int unsigned DRIVE_DLY_NS    = 1;

    // Trace commands
    localparam logic [7:0] CMD_ACCESS = 8'h1;
    localparam logic [7:0] CMD_READ   = 8'h2;
    localparam logic [7:0] CMD_OUTS   = 8'h3;
    localparam logic [7:0] CMD_LEVEL  = 8'h4;

    logic clk;
    logic pwrup_rst_n_sync;
    logic ext_rst_n;
    logic ext_cpu_rst_n;
    logic ext_ndm_rst_n;
    logic ext_hart_rst_n;
    logic ch_sel;
    logic ch_id;
    logic ch_capture;
    logic ch_shift;
    logic ch_update;
    logic ch_tdi;
    logic ch_tdo;
    logic [NUM_RST_CHAN-1:0] rst_n_vec;
    logic [NUM_RST_CHAN-1:0] qlfy_vec;
    logic sys_status;
    logic core_status;

    // One entry per trace line as {cmd, op, addr, data, expect}
    logic [39:0] step_q [$];
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0;

    // Last negedge view of the channel outputs
    logic [NUM_RST_CHAN-1:0] prev_rst;
    logic [NUM_RST_CHAN-1:0] prev_qlfy;

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    scu_top dut0 (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (ext_rst_n),
        .cpu_rst_n_i       (ext_cpu_rst_n),
        .ndm_rst_n_i       (ext_ndm_rst_n),
        .hart_rst_n_i      (ext_hart_rst_n),
        .ch_sel_i          (ch_sel),
        .ch_id_i           (ch_id),
        .ch_capture_i      (ch_capture),
        .ch_shift_i        (ch_shift),
        .ch_update_i       (ch_update),
        .ch_tdi_i          (ch_tdi),
        .ch_tdo_o          (ch_tdo),
        .rst_n_o           (rst_n_vec),
        .rdc_qlfy_o        (qlfy_vec),
        .sys_rst_status_o  (sys_status),
        .core_rst_status_o (core_status)
    );

    // --------------------
    // Compare and stop at the first mismatch
    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %02h, actual %02h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Edge plus drive delay
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY_NS);
    endtask

    task automatic load_trace();
        int fd;
        string line;
        logic [7:0] f_cmd;
        logic [7:0] f_op;
        logic [7:0] f_addr;
        logic [7:0] f_data;
        logic [7:0] f_exp;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open trace file %s", TRACE_FILE);
            $display("FAIL: see errors above");
            $fatal(1, "No trace file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment lines start with # and give no fields
                if ($sscanf(line, "%h %h %h %h %h", f_cmd, f_op, f_addr, f_data, f_exp) == 5) begin
                    step_q.push_back({f_cmd, f_op, f_addr, f_data, f_exp});
                end
            end
            $fclose(fd);
            if (step_q.size() == 0) begin
                $display("Error: trace file %s holds no steps", TRACE_FILE);
                $display("FAIL: see errors above");
                $fatal(1, "Empty trace");
            end
        end
    endtask

    // Capture then 8 shifts LSB first then update
    task automatic scan_access(input logic [DR_OP_W-1:0] op, input logic [DR_ADDR_W-1:0] addr,
                               input logic [DR_DATA_W-1:0] data);
        logic [DR_W-1:0] word;
        word       = {op, addr, data};
        ch_sel     = 1'b1;
        ch_capture = 1'b1;
        next_cycle();
        ch_capture = 1'b0;
        ch_shift   = 1'b1;
        for (int b = 0; b < DR_W; b++) begin
            ch_tdi = word[b];
            next_cycle();
        end
        ch_shift  = 1'b0;
        ch_tdi    = 1'b0;
        ch_update = 1'b1;
        next_cycle();
        ch_update = 1'b0;
        ch_sel    = 1'b0;
    endtask

    // Capture the shadow and collect it from tdo
    task automatic capture_shadow(output logic [DR_W-1:0] word);
        ch_sel     = 1'b1;
        ch_capture = 1'b1;
        next_cycle();
        ch_capture = 1'b0;
        ch_shift   = 1'b1;
        for (int b = 0; b < DR_W; b++) begin
            word[b] = ch_tdo;
            next_cycle();
        end
        ch_shift = 1'b0;
        ch_sel   = 1'b0;
    endtask

    // --------------------
    task automatic run_step(input int idx, input logic [39:0] step);
        logic [7:0] cmd;
        logic [7:0] op;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] expected;
        logic [DR_W-1:0] word;
        string name;
        {cmd, op, addr, data, expected} = step;
        case (cmd)
            CMD_ACCESS: begin
                scan_access(op[DR_OP_W-1:0], addr[DR_ADDR_W-1:0], data[DR_DATA_W-1:0]);
            end
            CMD_READ: begin
                // Read value lands in the shadow and shows at the next capture
                name = $sformatf("step %0d read addr %0d", idx, addr);
                scan_access(OP_READ, addr[DR_ADDR_W-1:0], '0);
                capture_shadow(word);
                check_value(name, {OP_READ, addr[DR_ADDR_W-1:0], expected[DR_DATA_W-1:0]}, word);
            end
            CMD_OUTS: begin
                name = $sformatf("step %0d outputs", idx);
                repeat (data) next_cycle();
                check_value(name, expected, {sys_status, core_status, qlfy_vec, rst_n_vec});
            end
            CMD_LEVEL: begin
                {ext_hart_rst_n, ext_ndm_rst_n, ext_cpu_rst_n, ext_rst_n} = data[3:0];
            end
            default: begin
                $display("Error: unknown trace command %0h at step %0d", cmd, idx);
                $display("FAIL: see errors above");
                $fatal(1, "Bad trace");
            end
        endcase
    endtask

    // Qualifier must lead the reset on assertion and release with it
    always @(negedge clk) begin
        if (pwrup_rst_n_sync) begin
            for (int i = 0; i < NUM_RST_CHAN; i++) begin
                if (prev_rst[i] && !rst_n_vec[i]) begin
                    check_value($sformatf("chan %0d qualifier before reset", i), 8'h00,
                                {7'b0, prev_qlfy[i]});
                end
                if (!prev_rst[i] && rst_n_vec[i]) begin
                    check_value($sformatf("chan %0d qualifier at release", i), 8'h01,
                                {7'b0, qlfy_vec[i]});
                end
            end
            check_value("qualifier high in reset", 8'h00, {5'b0, qlfy_vec & ~rst_n_vec});
        end
        prev_rst  = rst_n_vec;
        prev_qlfy = qlfy_vec;
    end

    // Cycle budget from the trace length
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: trace not finished after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        pwrup_rst_n_sync = 1'b0;
        ext_rst_n        = 1'b1;
        ext_cpu_rst_n    = 1'b1;
        ext_ndm_rst_n    = 1'b1;
        ext_hart_rst_n   = 1'b1;
        ch_sel           = 1'b0;
        ch_id            = 1'b0;
        ch_capture       = 1'b0;
        ch_shift         = 1'b0;
        ch_update        = 1'b0;
        ch_tdi           = 1'b0;
        load_trace();
        cycle_limit = step_q.size() * CYCLES_PER_STEP + 50;
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY_NS);
        pwrup_rst_n_sync = 1'b1;
        foreach (step_q[i]) begin
            run_step(i, step_q[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule : tb_scu

// File: testbench/scu_trace.txt
# Columns in hex: cmd op addr data expect
# cmd 1 scan access, 2 read addr and compare data, 3 wait data cycles then compare
# {sys_status, core_status, rdc_qlfy[2:0], rst_n[2:0]}, 4 drive {hart, ndm, cpu, rst} from data
3 0 0 6 3f
1 3 3 f 00
2 0 2 0 00
2 0 3 0 00
1 1 1 f 00
1 1 0 c 00
2 0 1 0 01
1 1 2 f 00
2 0 2 0 00
1 2 0 2 00
3 0 0 6 6d
2 0 0 0 02
1 3 1 1 00
3 0 0 6 49
1 2 0 1 00
3 0 0 6 c0
1 3 0 3 00
3 0 0 6 3f
2 0 0 0 00
2 0 3 0 07
1 3 3 5 00
2 0 3 0 02
4 0 0 e 00
3 0 0 6 c0
4 0 0 f 00
3 0 0 6 3f
4 0 0 7 00
3 0 0 6 49
2 0 2 0 06
4 0 0 f 00
3 0 0 6 3f

// File: flist.f
hw/scu_pkg.sv
hw/scu_dr_chain.sv
hw/scu_csr_regs.sv
hw/scu_rst_chan.sv
hw/scu_rst_status.sv
hw/scu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_scu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SCU testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_scu -f flist.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_scu > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || grep -q "PASS: all tests" sim.log
